/* bus_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter
  import bus_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  word_req_t req0_i,
  input  word_req_t req1_i,
  output logic      ready0_o,
  output logic      ready1_o,
  output word_req_t grant_req_o
);

  typedef enum logic {
    PrioHost0,
    PrioHost1
  } prio_e;

  prio_e prio_q;
  logic  both_req;

  assign both_req = req0_i.valid && req1_i.valid;

  assign ready0_o = req0_i.valid && (!req1_i.valid || prio_q == PrioHost0);
  assign ready1_o = req1_i.valid && (!req0_i.valid || prio_q == PrioHost1);

  always_comb begin
    grant_req_o = ready1_o ? req1_i : req0_i;
    grant_req_o.valid = ready0_o || ready1_o;
  end

  // Only contended grants move the pointer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q <= PrioHost0;
    end else if (both_req) begin
      prio_q <= ready0_o ? PrioHost1 : PrioHost0;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(ready0_o && ready1_o));

  // Loser of a contended cycle is served next if it still holds its request
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (both_req && ready0_o) |=> (!req1_i.valid || ready1_o));

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (both_req && ready1_o) |=> (!req0_i.valid || ready0_o));

endmodule

`default_nettype wire

/* bus_pkg.sv */
`default_nettype none

package bus_pkg;

  parameter int WideDataWidth = 128;
  parameter int WordWidth = 32;
  parameter int LaneCount = WideDataWidth / WordWidth;
  parameter int IntgWidth = 7;
  parameter int SourceWidth = 3;
  parameter int AddrWidth = 32;
  parameter int WideMaskWidth = WideDataWidth / 8;
  parameter int WordBytes = WordWidth / 8;

  typedef logic [$clog2(LaneCount)-1:0] lane_t;

  // Request opcodes as on the reference bus
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } opcode_e;

  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } rsp_opcode_e;

  typedef struct packed {
    logic                     valid;
    opcode_e                  opcode;
    logic [1:0]               size;
    logic [SourceWidth-1:0]   source;
    logic [AddrWidth-1:0]     address;
    logic [WideMaskWidth-1:0] mask;
    logic [WideDataWidth-1:0] data;
  } wide_req_t;

  // One word of a wide request, after lane selection
  typedef struct packed {
    logic                   valid;
    logic                   write;
    logic [SourceWidth-1:0] source;
    lane_t                  lane;
    logic [AddrWidth-1:0]   addr;
    logic [WordBytes-1:0]   be;
    logic [WordWidth-1:0]   wdata;
  } word_req_t;

  typedef struct packed {
    logic                     valid;
    rsp_opcode_e              opcode;
    logic [SourceWidth-1:0]   source;
    logic                     error;
    logic [WideDataWidth-1:0] data;
    logic [IntgWidth-1:0]     data_intg;
    logic [IntgWidth-1:0]     rsp_intg;
  } wide_rsp_t;

  // Hamming-style code with an inverted overall parity bit
  function automatic logic [IntgWidth-1:0] intg_encode(logic [WordWidth-1:0] data);
    logic [IntgWidth-1:0] code;
    code = '0;
    for (int i = 0; i < WordWidth; i++) begin
      for (int j = 0; j < 5; j++) begin
        if (i[j]) begin
          code[j] = code[j] ^ data[i];
        end
      end
    end
    code[5] = ^data;
    code[6] = ~(^code[5:0]);
    return code;
  endfunction

endpackage

`default_nettype wire

/* files.f */
+incdir+.
bus_pkg.sv
lane_select.sv
bus_arbiter.sv
word_sram.sv
rsp_integrity.sv
shared_mem_top.sv
tb_shared_mem.sv

/* lane_select.sv */
`timescale 1ns/1ns
`default_nettype none

module lane_select
  import bus_pkg::*;
#(
  parameter int MemDepth = 1024
) (
  input  wide_req_t wide_req_i,
  output word_req_t word_req_o
);

  localparam int WideShift = $clog2(WideMaskWidth);
  localparam int LaneShift = $clog2(LaneCount);
  localparam logic [AddrWidth-1:0] IdxMask = AddrWidth'(MemDepth - 1);

  logic [WideMaskWidth-1:0] mask;
  lane_t lane;

  // Reads carry no host mask, so derive it from size and offset
  always_comb begin
    logic [WideMaskWidth-1:0] run;
    run = WideMaskWidth'((1 << (1 << wide_req_i.size)) - 1);
    if (wide_req_i.opcode == Get) begin
      mask = run << wide_req_i.address[WideShift-1:0];
    end else begin
      mask = wide_req_i.mask;
    end
  end

  // Lowest lane with any byte enabled wins
  always_comb begin
    lane = '0;
    for (int i = LaneCount - 1; i >= 0; i--) begin
      if (|mask[i*WordBytes +: WordBytes]) begin
        lane = lane_t'(i);
      end
    end
  end

  always_comb begin
    logic [AddrWidth-1:0] line_addr;
    line_addr = (wide_req_i.address >> WideShift) << LaneShift;
    word_req_o.valid = wide_req_i.valid;
    word_req_o.write = wide_req_i.opcode != Get;
    word_req_o.source = wide_req_i.source;
    word_req_o.lane = lane;
    word_req_o.addr = (line_addr | AddrWidth'(lane)) & IdxMask;
    word_req_o.be = mask[lane*WordBytes +: WordBytes];
    word_req_o.wdata = wide_req_i.data[lane*WordWidth +: WordWidth];
  end

  // A put that enables no byte ends up as an error response
  always_comb begin
    if (wide_req_i.valid && wide_req_i.opcode != Get) begin
      assert (|wide_req_i.mask)
        else $warning("put with all-zero byte mask from source %0d", wide_req_i.source);
    end
  end

endmodule

`default_nettype wire

/* rsp_integrity.sv */
`timescale 1ns/1ns
`default_nettype none

module rsp_integrity
  import bus_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  word_req_t              grant_req_i,
  input  logic                   rvalid_i,
  input  logic [SourceWidth-1:0] rsp_source_i,
  input  logic                   rsp_error_i,
  input  logic [WordWidth-1:0]   rdata_i,
  output wide_rsp_t              host0_rsp_o,
  output wide_rsp_t              host1_rsp_o
);

  localparam int SourceCount = 1 << SourceWidth;

  typedef struct packed {
    logic  write;
    lane_t lane;
  } lane_entry_t;

  lane_entry_t lane_table_q [SourceCount];
  lane_entry_t entry;
  wide_rsp_t   rsp;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < SourceCount; i++) begin
        lane_table_q[i] <= '0;
      end
    end else if (grant_req_i.valid) begin
      lane_table_q[grant_req_i.source] <= '{write: grant_req_i.write, lane: grant_req_i.lane};
    end
  end

  assign entry = lane_table_q[rsp_source_i];

  always_comb begin
    rsp = '0;
    rsp.valid = rvalid_i;
    rsp.opcode = entry.write ? AccessAck : AccessAckData;
    rsp.source = rsp_source_i;
    rsp.error = rsp_error_i;
    rsp.data[entry.lane*WordWidth +: WordWidth] = rdata_i;
    rsp.data_intg = intg_encode(rdata_i);
    // Metadata word: opcode in 2:0, size 2 in 4:3, error in 5
    rsp.rsp_intg = intg_encode(WordWidth'({rsp_error_i, 2'b10, rsp.opcode}));
  end

  // Steer by host bit of the source
  always_comb begin
    host0_rsp_o = rsp;
    host1_rsp_o = rsp;
    host0_rsp_o.valid = rvalid_i && !rsp_source_i[SourceWidth-1];
    host1_rsp_o.valid = rvalid_i && rsp_source_i[SourceWidth-1];
  end

  // Memory answers exactly one cycle after a grant, for the same source
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i |-> ($past(grant_req_i.valid) && rsp_source_i == $past(grant_req_i.source)));

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_shared_mem -o tb_shared_mem
./obj_dir/tb_shared_mem | tee sim.log

if grep -q "ERRORS FOUND" sim.log || ! grep -q "NO ERRORS" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"

/* shared_mem_top.sv */
`timescale 1ns/1ns
`default_nettype none

module shared_mem_top
  import bus_pkg::*;
#(
  parameter int MemDepth = 1024
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  wide_req_t host0_req_i,
  input  wide_req_t host1_req_i,
  output logic      host0_ready_o,
  output logic      host1_ready_o,
  output wide_rsp_t host0_rsp_o,
  output wide_rsp_t host1_rsp_o
);

  word_req_t              word_req0;
  word_req_t              word_req1;
  word_req_t              grant_req;
  logic                   sram_rvalid;
  logic [SourceWidth-1:0] sram_source;
  logic                   sram_error;
  logic [WordWidth-1:0]   sram_rdata;

  lane_select #(
    .MemDepth(MemDepth)
  ) u_lane_select0 (
    .wide_req_i(host0_req_i),
    .word_req_o(word_req0)
  );

  lane_select #(
    .MemDepth(MemDepth)
  ) u_lane_select1 (
    .wide_req_i(host1_req_i),
    .word_req_o(word_req1)
  );

  bus_arbiter u_bus_arbiter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req0_i     (word_req0),
    .req1_i     (word_req1),
    .ready0_o   (host0_ready_o),
    .ready1_o   (host1_ready_o),
    .grant_req_o(grant_req)
  );

  word_sram #(
    .MemDepth(MemDepth)
  ) u_word_sram (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (grant_req),
    .rvalid_o    (sram_rvalid),
    .rsp_source_o(sram_source),
    .rsp_error_o (sram_error),
    .rdata_o     (sram_rdata)
  );

  rsp_integrity u_rsp_integrity (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .grant_req_i (grant_req),
    .rvalid_i    (sram_rvalid),
    .rsp_source_i(sram_source),
    .rsp_error_i (sram_error),
    .rdata_i     (sram_rdata),
    .host0_rsp_o (host0_rsp_o),
    .host1_rsp_o (host1_rsp_o)
  );

endmodule

`default_nettype wire

/* tb_tasks.svh */
  function automatic wide_req_t make_req(opcode_e op, logic [1:0] size, logic [2:0] src,
                                         logic [31:0] addr, logic [15:0] mask);
    wide_req_t r;
    r.valid = 1'b1;
    r.opcode = op;
    r.size = size;
    r.source = src;
    r.address = addr;
    r.mask = mask;
    r.data = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
    return r;
  endfunction

  function automatic wide_req_t full_put(logic [2:0] src, logic [31:0] addr);
    return make_req(PutFullData, 2'd2, src, addr, 16'hf << (4 * addr[3:2]));
  endfunction

  // The DUT ignores the random host mask of a read
  function automatic wide_req_t get_req(logic [2:0] src, logic [31:0] addr, logic [1:0] size);
    return make_req(Get, size, src, addr, 16'(rand_bits(16)));
  endfunction

  function automatic logic [31:0] line_addr(logic [3:0] offset);
    logic [31:0] line;
    line = rand_bits(12);
    return {line[27:0], offset};
  endfunction

  // Starts just after a rising edge and returns just after the accepting edge
  task automatic issue(int host, wide_req_t r);
    int   waited;
    int   allowed;
    logic ready;
    waited = 0;
    if (host == 0) begin
      host0_req <= r;
    end else begin
      host1_req <= r;
    end
    @(negedge clk_i);
    ready = (host == 0) ? host0_ready : host1_ready;
    // Only a contended request may lose one cycle to the other host
    allowed = ((host == 0) ? host1_req.valid : host0_req.valid) ? 1 : 0;
    while (!ready && waited < MaxWait) begin
      @(negedge clk_i);
      waited++;
      ready = (host == 0) ? host0_ready : host1_ready;
    end
    if (!ready) begin
      errors++;
      $display("Host %0d request was never accepted in test %s", host, test_name);
    end else if (waited > allowed) begin
      errors++;
      $display("Host %0d waited %0d cycles for a grant in test %s", host, waited, test_name);
    end
    @(posedge clk_i);
  endtask

  task automatic idle(int host);
    if (host == 0) begin
      host0_req.valid <= 1'b0;
    end else begin
      host1_req.valid <= 1'b0;
    end
  endtask

  // Lets the last response pass before the next test renames itself
  task automatic settle();
    idle(0);
    idle(1);
    @(posedge clk_i);
  endtask

  task automatic run_reset_test();
    for (int i = 0; i < 3; i++) begin
      @(negedge clk_i);
      check("host 0 ready", value_t'(1'b0), value_t'(host0_ready));
      check("host 1 ready", value_t'(1'b0), value_t'(host1_ready));
    end
    @(posedge clk_i);
  endtask

  task automatic run_full_word_test();
    logic [31:0] base;
    test_name = "full word";
    base = line_addr(4'h0);
    for (int k = 0; k < 4; k++) begin
      issue(0, full_put(3'd1, base + 4 * k));
      issue(0, get_req(3'd2, base + 4 * k, 2'd2));
    end
    settle();
  endtask

  task automatic run_partial_test();
    logic [31:0] base;
    test_name = "partial put";
    base = line_addr(4'h0);
    for (int k = 0; k < 4; k++) begin
      issue(0, full_put(3'd3, base + 4 * k));
    end
    issue(0, make_req(PutPartialData, 2'd2, 3'd3, base, 16'h0f60));
    issue(0, make_req(PutPartialData, 2'd2, 3'd1, base, 16'hc300));
    for (int k = 0; k < 4; k++) begin
      issue(0, get_req(3'd2, base + 4 * k, 2'd2));
    end
    settle();
  endtask

  task automatic run_narrow_read_test();
    logic [31:0] base;
    test_name = "narrow read";
    base = line_addr(4'h0);
    for (int k = 0; k < 4; k++) begin
      issue(0, full_put(3'd0, base + 4 * k));
    end
    for (int off = 0; off < 16; off++) begin
      issue(0, get_req(3'd1, base + off, 2'd0));
    end
    for (int off = 0; off < 16; off += 2) begin
      issue(0, get_req(3'd2, base + off, 2'd1));
    end
    settle();
  endtask

  // Host 0 stays in lane 1 and host 1 in lane 3
  task automatic run_contention_test();
    logic [31:0] base0;
    logic [31:0] base1;
    test_name = "contention";
    base0 = line_addr(4'h4);
    base1 = line_addr(4'hc);
    fork
      begin
        for (int i = 0; i < 3; i++) begin
          issue(0, full_put(3'd1, base0));
          issue(0, get_req(3'd2, base0, 2'd2));
        end
        idle(0);
      end
      begin
        for (int i = 0; i < 3; i++) begin
          issue(1, full_put(3'd5, base1));
          issue(1, get_req(3'd6, base1, 2'd2));
        end
        idle(1);
      end
    join
    settle();
  endtask

  task automatic run_zero_mask_test();
    logic [31:0] base;
    test_name = "zero mask";
    base = line_addr(4'h0);
    issue(1, full_put(3'd4, base));
    issue(1, make_req(PutPartialData, 2'd2, 3'd4, base, 16'h0000));
    issue(1, get_req(3'd7, base, 2'd2));
    settle();
  endtask

/* tb_shared_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_shared_mem
  import bus_pkg::*;
();

  localparam int MemDepth = 1024;
  localparam int IdxWidth = $clog2(MemDepth);
  localparam int MaxWait = 16;

  typedef logic [159:0] value_t;

  logic      clk_i;
  logic      rst_ni;
  wide_req_t host0_req;
  wide_req_t host1_req;
  logic      host0_ready;
  logic      host1_ready;
  wide_rsp_t host0_rsp;
  wide_rsp_t host1_rsp;

  // Byte-wide model of the word memory
  logic [7:0]  ref_mem [MemDepth*4];
  logic [31:0] lfsr;
  int          errors;
  string       test_name;
  logic        monitor_on;
  logic        prio;
  logic [1:0]  due_valid;
  wide_rsp_t   due [2];

  shared_mem_top #(
    .MemDepth(MemDepth)
  ) i_dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .host0_req_i  (host0_req),
    .host1_req_i  (host1_req),
    .host0_ready_o(host0_ready),
    .host1_ready_o(host1_ready),
    .host0_rsp_o  (host0_rsp),
    .host1_rsp_o  (host1_rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #2 clk_i = ~clk_i;
    end
  end

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return value;
  endfunction

  // Bit j covers the data bits whose index has bit j set
  function automatic logic [6:0] intg_code(logic [31:0] w);
    logic [6:0] c;
    c[0] = ^(w & 32'haaaaaaaa);
    c[1] = ^(w & 32'hcccccccc);
    c[2] = ^(w & 32'hf0f0f0f0);
    c[3] = ^(w & 32'hff00ff00);
    c[4] = ^(w & 32'hffff0000);
    c[5] = ^w;
    c[6] = ~(^c[5:0]);
    return c;
  endfunction

  task automatic check(string what, value_t expected, value_t actual);
    if (expected !== actual) begin
      errors++;
      $display("** Error %s: %s expected %0h, got %0h", test_name, what, expected, actual);
    end
  endtask

  // Expected response of an accepted request, applied to the byte model
  task automatic model_accept(input wide_req_t r, output wide_rsp_t exp);
    logic [15:0]         run;
    logic [15:0]         mask;
    logic [1:0]          lane;
    logic [3:0]          be;
    logic [31:0]         word;
    logic [IdxWidth-1:0] widx;
    run = 16'hff >> (8 - (1 << r.size));
    mask = (r.opcode == Get) ? run << r.address[3:0] : r.mask;
    lane = 2'd0;
    for (int i = 3; i >= 0; i--) begin
      if (mask[4*i +: 4] != 4'h0) begin
        lane = 2'(i);
      end
    end
    be = mask[4*lane +: 4];
    widx = IdxWidth'({r.address[31:4], lane});
    word = {ref_mem[{widx, 2'd3}], ref_mem[{widx, 2'd2}],
            ref_mem[{widx, 2'd1}], ref_mem[{widx, 2'd0}]};
    exp = '0;
    exp.valid = 1'b1;
    exp.source = r.source;
    if (r.opcode == Get) begin
      exp.opcode = AccessAckData;
      exp.data[32*lane +: 32] = word;
    end else begin
      exp.opcode = AccessAck;
      exp.error = (be == 4'h0);
      word = '0;
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          ref_mem[{widx, 2'(b)}] = r.data[32*lane + 8*b +: 8];
        end
      end
    end
    exp.data_intg = intg_code(word);
    exp.rsp_intg = intg_code({26'h0, exp.error, 2'd2, exp.opcode});
  endtask

  // Responses are due exactly one cycle after acceptance
  always @(negedge clk_i) begin
    if (monitor_on) begin
      check("host 0 response valid", value_t'(due_valid[0]), value_t'(host0_rsp.valid));
      check("host 1 response valid", value_t'(due_valid[1]), value_t'(host1_rsp.valid));
      if (due_valid[0] && host0_rsp.valid) begin
        check("host 0 response", value_t'(due[0]), value_t'(host0_rsp));
      end
      if (due_valid[1] && host1_rsp.valid) begin
        check("host 1 response", value_t'(due[1]), value_t'(host1_rsp));
      end
      if (host0_req.valid && host1_req.valid) begin
        check("contended grant to host 1", value_t'(prio), value_t'(host1_ready));
        prio = ~prio;
      end
      due_valid = {host1_ready, host0_ready};
      if (host0_ready) begin
        model_accept(host0_req, due[0]);
      end
      if (host1_ready) begin
        model_accept(host1_req, due[1]);
      end
    end
  end

  `include "tb_tasks.svh"

  initial begin
    errors = 0;
    lfsr = 32'hce8549ab;
    test_name = "reset";
    monitor_on = 1'b0;
    prio = 1'b0;
    due_valid = 2'b00;
    host0_req = '0;
    host1_req = '0;
    rst_ni = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    monitor_on = 1'b1;
    run_reset_test();
    run_full_word_test();
    run_partial_test();
    run_narrow_read_test();
    run_contention_test();
    run_zero_mask_test();
    $display("Simulation done with %0d errors", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* word_sram.sv */
`timescale 1ns/1ns
`default_nettype none

module word_sram
  import bus_pkg::*;
#(
  parameter int MemDepth = 1024
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  word_req_t              req_i,
  output logic                   rvalid_o,
  output logic [SourceWidth-1:0] rsp_source_o,
  output logic                   rsp_error_o,
  output logic [WordWidth-1:0]   rdata_o
);

  localparam int IdxWidth = $clog2(MemDepth);

  logic [WordWidth-1:0] mem [MemDepth];
  logic [IdxWidth-1:0]  idx;

  assign idx = req_i.addr[IdxWidth-1:0];

  always_ff @(posedge clk_i) begin
    if (req_i.valid && req_i.write) begin
      for (int b = 0; b < WordBytes; b++) begin
        if (req_i.be[b]) begin
          mem[idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  // Writes are acknowledged too, with zero data
  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      rsp_source_o <= req_i.source;
      rsp_error_o <= req_i.write && (req_i.be == '0);
      rdata_o <= req_i.write ? '0 : mem[idx];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i.valid;
    end
  end

endmodule

`default_nettype wire
